// ==== logic/accel_pkg.sv ====
`default_nettype none

package accel_pkg;

    localparam int VEC_LEN   = 4;   // Vector elements and output rows
    localparam int DATA_W    = 8;   // Signed input and weight elements
    localparam int ACC_W     = 20;  // Dot results and output accumulators
    localparam int ROW_W     = 2;   // Row index
    localparam int NUM_SLOTS = 3;   // Weight row slots

    // Slot a dot unit is working on
    typedef enum logic [1:0] {
        FREE = 2'd0,
        W1   = 2'd1,
        W2   = 2'd2,
        W3   = 2'd3
    } t_buffer_sel;

    typedef logic signed [DATA_W-1:0] t_elem;
    typedef logic signed [ACC_W-1:0]  t_acc;

    typedef t_elem [VEC_LEN-1:0] t_vector;      // 32 bits
    typedef t_acc  [VEC_LEN-1:0] t_out_vector;  // 80 bits

    typedef struct packed {
        logic [ROW_W-1:0] row_idx;  // Output row the result lands in
        t_vector          weights;
    } t_weight_row;

    // One-hot slot mask for a selection, bit 0 is W1
    function automatic logic [NUM_SLOTS-1:0] slot_mask(input t_buffer_sel sel);
        logic [NUM_SLOTS-1:0] mask;
        mask = '0;
        if (sel != FREE) begin
            mask[int'(sel) - 1] = 1'b1;
        end
        return mask;
    endfunction

endpackage

`default_nettype wire

// ==== logic/input_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module input_buffer
    import accel_pkg::*;
(
    input  logic        Clock,
    input  logic        rst,
    input  logic        load_input,
    input  logic        end_input,
    input  t_vector     input_data,
    input  logic        move_out_to_in,
    input  t_out_vector out_vector,
    output t_vector     in_vector,
    output logic        in_use_by_accel
);

    // Clamp an accumulator to the signed element range
    function automatic t_elem saturate(input t_acc value);
        t_acc hi;
        t_acc lo;
        hi = t_acc'(2 ** (DATA_W - 1) - 1);
        lo = -t_acc'(2 ** (DATA_W - 1));
        if (value > hi) begin
            return t_elem'(hi);
        end else if (value < lo) begin
            return t_elem'(lo);
        end
        return t_elem'(value);
    endfunction

    always_ff @(posedge Clock) begin
        if (rst) begin
            in_use_by_accel <= 1'b0;
        end else if (load_input) begin
            in_use_by_accel <= 1'b1;
        end else if (end_input) begin
            in_use_by_accel <= 1'b0;
        end
    end

    // Host load wins over a move in the same cycle
    always_ff @(posedge Clock) begin
        if (rst) begin
            in_vector <= '0;
        end else if (load_input) begin
            in_vector <= input_data;
        end else if (move_out_to_in) begin
            for (int i = 0; i < VEC_LEN; i++) begin
                in_vector[i] <= saturate(out_vector[i]);  // Chain into next layer
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/weight_slots.sv ====
`timescale 1ns/1ps
`default_nettype none

module weight_slots
    import accel_pkg::*;
(
    input  logic                 Clock,
    input  logic                 rst,
    input  logic                 weight_load,
    input  t_buffer_sel          weight_slot,
    input  t_weight_row          weight_data,
    input  logic [NUM_SLOTS-1:0] slot_release,
    input  t_buffer_sel          assign_m1,
    input  t_buffer_sel          assign_m2,
    output logic [NUM_SLOTS-1:0] slot_in_use,
    output t_weight_row          row_m1,
    output t_weight_row          row_m2
);

    t_weight_row          rows [NUM_SLOTS];
    logic [NUM_SLOTS-1:0] wr_mask;  // Accepted host write, one-hot
    logic [NUM_SLOTS-1:0] m1_sel;
    logic [NUM_SLOTS-1:0] m2_sel;

    // Writes to FREE or to a busy slot drop out here
    assign wr_mask = weight_load ? (slot_mask(weight_slot) & ~slot_in_use) : '0;

    assign m1_sel = slot_mask(assign_m1);
    assign m2_sel = slot_mask(assign_m2);

    always_ff @(posedge Clock) begin
        if (rst) begin
            slot_in_use <= '0;
        end else begin
            slot_in_use <= (slot_in_use & ~slot_release) | wr_mask;
        end
    end

    always_ff @(posedge Clock) begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (wr_mask[i]) begin
                rows[i] <= weight_data;
            end
        end
    end

    // One-hot read mux per unit
    always_comb begin
        row_m1 = '0;  // Unassigned unit sees zeros
        row_m2 = '0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (m1_sel[i]) begin
                row_m1 = rows[i];
            end
            if (m2_sel[i]) begin
                row_m2 = rows[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/mul_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module mul_controller
    import accel_pkg::*;
(
    input  logic                 Clock,
    input  logic                 rst,
    input  logic                 in_use_by_accel,
    input  logic [NUM_SLOTS-1:0] slot_in_use,
    input  logic                 out_valid_m1,
    input  logic                 out_valid_m2,
    input  logic                 done_layer,
    output t_buffer_sel          assign_m1,
    output t_buffer_sel          assign_m2,
    output logic                 start_m1,
    output logic                 start_m2,
    output logic [NUM_SLOTS-1:0] slot_release,
    output logic                 clear_output,
    output logic                 move_out_to_in
);

    logic [NUM_SLOTS-1:0] avail;
    t_buffer_sel          pick_m1;
    t_buffer_sel          pick_m2;
    logic                 in_use_q;
    logic                 done_layer_q;

    // Lowest-numbered candidate slot, FREE when none
    function automatic t_buffer_sel lowest_slot(input logic [NUM_SLOTS-1:0] cand);
        t_buffer_sel pick;
        pick = FREE;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (cand[i]) begin
                pick = t_buffer_sel'(i + 1);
            end
        end
        return pick;
    endfunction

    // Slots being released this cycle are still flagged, so mask them out
    assign avail = slot_in_use & ~slot_release;

    always_comb begin
        pick_m1 = FREE;
        pick_m2 = FREE;
        if (in_use_by_accel && assign_m1 == FREE) begin
            pick_m1 = lowest_slot(avail & ~slot_mask(assign_m2));  // Unit 1 first
        end
        if (in_use_by_accel && assign_m2 == FREE) begin
            pick_m2 = lowest_slot(avail & ~slot_mask(assign_m1) & ~slot_mask(pick_m1));
        end
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            assign_m1    <= FREE;
            assign_m2    <= FREE;
            start_m1     <= 1'b0;
            start_m2     <= 1'b0;
            slot_release <= '0;
        end else begin
            start_m1 <= (pick_m1 != FREE);
            start_m2 <= (pick_m2 != FREE);

            // Finished unit hands its slot back next cycle
            slot_release <= (out_valid_m1 ? slot_mask(assign_m1) : '0)
                          | (out_valid_m2 ? slot_mask(assign_m2) : '0);

            if (out_valid_m1) begin
                assign_m1 <= FREE;
            end else if (pick_m1 != FREE) begin
                assign_m1 <= pick_m1;
            end

            if (out_valid_m2) begin
                assign_m2 <= FREE;
            end else if (pick_m2 != FREE) begin
                assign_m2 <= pick_m2;
            end
        end
    end

    // Rising edges of the in-use level and done_layer
    always_ff @(posedge Clock) begin
        if (rst) begin
            in_use_q       <= 1'b0;
            done_layer_q   <= 1'b0;
            clear_output   <= 1'b0;
            move_out_to_in <= 1'b0;
        end else begin
            in_use_q       <= in_use_by_accel;
            done_layer_q   <= done_layer;
            clear_output   <= in_use_by_accel && !in_use_q;  // New input, fresh outputs
            move_out_to_in <= done_layer && !done_layer_q;
        end
    end

endmodule

`default_nettype wire

// ==== logic/dot_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module dot_unit
    import accel_pkg::*;
(
    input  logic             Clock,
    input  logic             rst,
    input  logic             start,
    input  t_weight_row      row,
    input  t_vector          in_vector,
    output logic             out_valid,
    output logic [ACC_W-1:0] result,
    output logic [ROW_W-1:0] result_row
);

    t_weight_row                row_q;     // Latched on start
    t_acc                       acc;
    logic [ROW_W-1:0]           elem_cnt;  // Element being processed
    logic                       busy;
    logic                       last_elem;
    logic signed [2*DATA_W-1:0] product;

    assign last_elem = (elem_cnt == ROW_W'(VEC_LEN - 1));

    // Full-precision signed product of the current element pair
    assign product = row_q.weights[elem_cnt] * in_vector[elem_cnt];

    always_ff @(posedge Clock) begin
        if (rst) begin
            busy      <= 1'b0;
            elem_cnt  <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= busy && last_elem;  // One cycle after the last MAC
            if (start) begin
                busy     <= 1'b1;
                elem_cnt <= '0;
            end else if (busy) begin
                elem_cnt <= elem_cnt + 1'b1;
                if (last_elem) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (start) begin
            row_q <= row;
            acc   <= '0;
        end else if (busy) begin
            acc <= acc + t_acc'(product);  // Sign-extended into the accumulator
        end
    end

    assign result     = acc;
    assign result_row = row_q.row_idx;

endmodule

`default_nettype wire

// ==== logic/output_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module output_buffer
    import accel_pkg::*;
(
    input  logic             Clock,
    input  logic             rst,
    input  logic             clear_output,
    input  logic             valid_a,
    input  logic [ACC_W-1:0] result_a,
    input  logic [ROW_W-1:0] row_a,
    input  logic             valid_b,
    input  logic [ACC_W-1:0] result_b,
    input  logic [ROW_W-1:0] row_b,
    output t_out_vector      out_vector
);

    t_out_vector add_a;  // Port A contribution per row
    t_out_vector add_b;

    // Steer each result to its row, zero elsewhere
    always_comb begin
        for (int i = 0; i < VEC_LEN; i++) begin
            add_a[i] = (valid_a && row_a == ROW_W'(i)) ? result_a : '0;
            add_b[i] = (valid_b && row_b == ROW_W'(i)) ? result_b : '0;
        end
    end

    // Clear beats any addition in the same cycle
    always_ff @(posedge Clock) begin
        if (rst || clear_output) begin
            out_vector <= '0;
        end else begin
            for (int i = 0; i < VEC_LEN; i++) begin
                out_vector[i] <= out_vector[i] + add_a[i] + add_b[i];  // Same row sums both
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/accel_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module accel_core
    import accel_pkg::*;
(
    input  logic                 Clock,
    input  logic                 rst,
    input  logic                 load_input,
    input  logic                 end_input,
    input  t_vector              input_data,
    input  logic                 weight_load,
    input  t_buffer_sel          weight_slot,
    input  t_weight_row          weight_data,
    input  logic                 done_layer,
    output logic [NUM_SLOTS-1:0] weight_in_use,
    output t_out_vector          out_vector,
    output logic                 in_use_by_accel
);

    t_vector              in_vector;
    logic [NUM_SLOTS-1:0] slot_release;
    t_buffer_sel          assign_m1;
    t_buffer_sel          assign_m2;
    logic                 start_m1;
    logic                 start_m2;
    t_weight_row          row_m1;
    t_weight_row          row_m2;
    logic                 out_valid_m1;
    logic                 out_valid_m2;
    logic [ACC_W-1:0]     result_m1;
    logic [ACC_W-1:0]     result_m2;
    logic [ROW_W-1:0]     result_row_m1;
    logic [ROW_W-1:0]     result_row_m2;
    logic                 clear_output;
    logic                 move_out_to_in;

    input_buffer input_buffer_inst (
        .Clock           (Clock),
        .rst             (rst),
        .load_input      (load_input),
        .end_input       (end_input),
        .input_data      (input_data),
        .move_out_to_in  (move_out_to_in),
        .out_vector      (out_vector),
        .in_vector       (in_vector),
        .in_use_by_accel (in_use_by_accel)
    );

    // Slot flags double as the host's weight_in_use status
    weight_slots weight_slots_inst (
        .Clock        (Clock),
        .rst          (rst),
        .weight_load  (weight_load),
        .weight_slot  (weight_slot),
        .weight_data  (weight_data),
        .slot_release (slot_release),
        .assign_m1    (assign_m1),
        .assign_m2    (assign_m2),
        .slot_in_use  (weight_in_use),
        .row_m1       (row_m1),
        .row_m2       (row_m2)
    );

    mul_controller mul_controller_inst (
        .Clock           (Clock),
        .rst             (rst),
        .in_use_by_accel (in_use_by_accel),
        .slot_in_use     (weight_in_use),
        .out_valid_m1    (out_valid_m1),
        .out_valid_m2    (out_valid_m2),
        .done_layer      (done_layer),
        .assign_m1       (assign_m1),
        .assign_m2       (assign_m2),
        .start_m1        (start_m1),
        .start_m2        (start_m2),
        .slot_release    (slot_release),
        .clear_output    (clear_output),
        .move_out_to_in  (move_out_to_in)
    );

    dot_unit dot_m1 (
        .Clock      (Clock),
        .rst        (rst),
        .start      (start_m1),
        .row        (row_m1),
        .in_vector  (in_vector),
        .out_valid  (out_valid_m1),
        .result     (result_m1),
        .result_row (result_row_m1)
    );

    dot_unit dot_m2 (
        .Clock      (Clock),
        .rst        (rst),
        .start      (start_m2),
        .row        (row_m2),
        .in_vector  (in_vector),
        .out_valid  (out_valid_m2),
        .result     (result_m2),
        .result_row (result_row_m2)
    );

    output_buffer output_buffer_inst (
        .Clock        (Clock),
        .rst          (rst),
        .clear_output (clear_output),
        .valid_a      (out_valid_m1),
        .result_a     (result_m1),
        .row_a        (result_row_m1),
        .valid_b      (out_valid_m2),
        .result_b     (result_m2),
        .row_b        (result_row_m2),
        .out_vector   (out_vector)
    );

endmodule

`default_nettype wire

// ==== sim/accel_core_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module accel_core_chk
    import accel_pkg::*;
(
    input logic        Clock,
    input logic        rst,
    input t_buffer_sel assign_m1,
    input t_buffer_sel assign_m2,
    input logic        start_m1,
    input logic        start_m2,
    input logic        clear_output,
    input logic        move_out_to_in
);

    // Two units never hold the same slot
    shared_slot: assert property (@(posedge Clock) disable iff (rst)
        assign_m1 == FREE || assign_m1 != assign_m2)
        else $error("Both dot units assigned to the same slot");

    start_m1_pulse: assert property (@(posedge Clock) disable iff (rst)
        start_m1 |-> (assign_m1 != FREE) ##1 !start_m1)
        else $error("start_m1 without a slot or longer than one cycle");

    start_m2_pulse: assert property (@(posedge Clock) disable iff (rst)
        start_m2 |-> (assign_m2 != FREE) ##1 !start_m2)
        else $error("start_m2 without a slot or longer than one cycle");

    move_pulse: assert property (@(posedge Clock) disable iff (rst)
        move_out_to_in |=> !move_out_to_in)
        else $error("move_out_to_in held for more than one cycle");

    clear_pulse: assert property (@(posedge Clock) disable iff (rst)
        clear_output |=> !clear_output)
        else $error("clear_output held for more than one cycle");

endmodule

bind mul_controller accel_core_chk chk_inst (
    .Clock          (Clock),
    .rst            (rst),
    .assign_m1      (assign_m1),
    .assign_m2      (assign_m2),
    .start_m1       (start_m1),
    .start_m2       (start_m2),
    .clear_output   (clear_output),
    .move_out_to_in (move_out_to_in)
);

`default_nettype wire

// ==== sim/accel_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module accel_core_tb
    import accel_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 4000;  // About 600 cycles of tests plus margin
    localparam int IDLE_LIMIT     = 200;
    localparam int ELEM_MAX       = 2 ** (DATA_W - 1) - 1;
    localparam int ELEM_MIN       = -(2 ** (DATA_W - 1));

    logic                 Clock;
    logic                 rst;
    logic                 load_input;
    logic                 end_input;
    t_vector              input_data;
    logic                 weight_load;
    t_buffer_sel          weight_slot;
    t_weight_row          weight_data;
    logic                 done_layer;
    logic [NUM_SLOTS-1:0] weight_in_use;
    t_out_vector          out_vector;
    logic                 in_use_by_accel;

    int exp_acc [VEC_LEN];  // Model accumulators
    int exp_vec [VEC_LEN];  // Model input vector
    int errors;
    int checks;
    int cycles;

    accel_core accel_core_inst (
        .Clock           (Clock),
        .rst             (rst),
        .load_input      (load_input),
        .end_input       (end_input),
        .input_data      (input_data),
        .weight_load     (weight_load),
        .weight_slot     (weight_slot),
        .weight_data     (weight_data),
        .done_layer      (done_layer),
        .weight_in_use   (weight_in_use),
        .out_vector      (out_vector),
        .in_use_by_accel (in_use_by_accel)
    );

    initial Clock = 1'b0;
    always #2 Clock = ~Clock;

    task automatic step();
        @(posedge Clock);
        #1;  // Drive point just after the edge
    endtask

    function automatic int clamp_elem(input int value);
        if (value > ELEM_MAX) begin
            return ELEM_MAX;
        end else if (value < ELEM_MIN) begin
            return ELEM_MIN;
        end
        return value;
    endfunction

    // Drop the in-use level and reload, so the outputs clear
    task automatic begin_layer(input t_vector vec);
        end_input = 1'b1;
        step();
        end_input  = 1'b0;
        load_input = 1'b1;
        input_data = vec;
        step();
        load_input = 1'b0;
        step();  // clear_output pulse
        step();
        for (int i = 0; i < VEC_LEN; i++) begin
            exp_vec[i] = int'($signed(vec[i]));
            exp_acc[i] = 0;
        end
    endtask

    // Done rises with the reload, so the move lands one edge later over the host vector
    task automatic chain_layer(input t_vector host_vec);
        end_input = 1'b1;
        step();
        end_input  = 1'b0;
        load_input = 1'b1;
        input_data = host_vec;
        done_layer = 1'b1;
        step();
        load_input = 1'b0;
        step();
        done_layer = 1'b0;
        step();
        step();
        for (int i = 0; i < VEC_LEN; i++) begin
            exp_vec[i] = clamp_elem(exp_acc[i]);
            exp_acc[i] = 0;
        end
    endtask

    task automatic write_weight(input t_buffer_sel slot, input logic [ROW_W-1:0] idx,
                                input t_vector w);
        weight_load         = 1'b1;
        weight_slot         = slot;
        weight_data.row_idx = idx;
        weight_data.weights = w;
        step();
        weight_load = 1'b0;
    endtask

    task automatic expect_row(input logic [ROW_W-1:0] idx, input t_vector w);
        int sum;
        sum = 0;
        for (int i = 0; i < VEC_LEN; i++) begin
            sum += int'($signed(w[i])) * exp_vec[i];
        end
        exp_acc[idx] += sum;
    endtask

    task automatic wait_idle(input string name);
        int waited;
        waited = 0;
        while (weight_in_use != '0 && waited < IDLE_LIMIT) begin
            @(negedge Clock);
            waited++;
        end
        assert (weight_in_use == '0) else begin
            errors++;
            $display("%s: weight slots still busy after %0d cycles, DUT hung", name, waited);
        end
        step();
    endtask

    task automatic check_outputs(input string name);
        for (int r = 0; r < VEC_LEN; r++) begin
            checks++;
            assert (out_vector[r] === t_acc'(exp_acc[r])) else begin
                errors++;
                $display("MISMATCH %s row %0d: expected %0d, actual %0d",
                         name, r, t_acc'(exp_acc[r]), out_vector[r]);
            end
        end
    endtask

    task automatic check_in_use(input string name, input logic expected);
        checks++;
        assert (in_use_by_accel === expected) else begin
            errors++;
            $display("MISMATCH %s in_use_by_accel: expected %b, actual %b",
                     name, expected, in_use_by_accel);
        end
    endtask

    task automatic test_single_row();
        begin_layer({8'sd4, -8'sd3, 8'sd2, 8'sd1});
        check_in_use("single_row", 1'b1);
        write_weight(W1, 2'd2, {8'sd1, 8'sd2, -8'sd5, 8'sd7});
        expect_row(2'd2, {8'sd1, 8'sd2, -8'sd5, 8'sd7});
        wait_idle("single_row");
        check_outputs("single_row");
    endtask

    // W3 waits for the first release
    task automatic test_three_slots();
        begin_layer({-8'sd7, 8'sd11, 8'sd5, -8'sd2});
        write_weight(W1, 2'd0, {8'sd3, 8'sd1, -8'sd4, 8'sd9});
        write_weight(W2, 2'd1, {-8'sd6, 8'sd2, 8'sd8, 8'sd1});
        write_weight(W3, 2'd3, {8'sd12, -8'sd3, 8'sd1, 8'sd5});
        expect_row(2'd0, {8'sd3, 8'sd1, -8'sd4, 8'sd9});
        expect_row(2'd1, {-8'sd6, 8'sd2, 8'sd8, 8'sd1});
        expect_row(2'd3, {8'sd12, -8'sd3, 8'sd1, 8'sd5});
        checks++;
        assert (weight_in_use === 3'b111) else begin
            errors++;
            $display("MISMATCH three_slots weight_in_use: expected %b, actual %b",
                     3'b111, weight_in_use);
        end
        wait_idle("three_slots");
        check_outputs("three_slots");
    endtask

    // Both slots fill while the input is idle, so both units report in the same cycle
    task automatic test_accumulation();
        end_input = 1'b1;
        step();
        end_input = 1'b0;
        check_in_use("accumulation", 1'b0);
        write_weight(W1, 2'd1, {8'sd2, 8'sd3, -8'sd1, 8'sd4});
        write_weight(W2, 2'd1, {-8'sd5, 8'sd1, 8'sd6, -8'sd2});
        begin_layer({8'sd20, -8'sd15, 8'sd9, 8'sd33});
        expect_row(2'd1, {8'sd2, 8'sd3, -8'sd1, 8'sd4});
        expect_row(2'd1, {-8'sd5, 8'sd1, 8'sd6, -8'sd2});
        wait_idle("accumulation");
        check_outputs("accumulation");
    endtask

    // Second write hits a busy slot and must be dropped
    task automatic test_ignored_write();
        begin_layer({8'sd1, 8'sd2, 8'sd3, 8'sd4});
        write_weight(W2, 2'd3, {8'sd10, 8'sd20, 8'sd30, 8'sd40});
        write_weight(W2, 2'd3, {-8'sd90, 8'sd77, -8'sd50, 8'sd66});
        expect_row(2'd3, {8'sd10, 8'sd20, 8'sd30, 8'sd40});
        wait_idle("ignored_write");
        check_outputs("ignored_write");
    endtask

    task automatic test_layer_chain();
        begin_layer({8'sd100, 8'sd90, -8'sd80, 8'sd70});
        write_weight(W1, 2'd0, {8'sd1, 8'sd1, 8'sd1, 8'sd1});    // Above 127
        write_weight(W2, 2'd1, {-8'sd1, -8'sd1, -8'sd1, -8'sd1});  // Below -128
        write_weight(W3, 2'd2, {8'sd0, 8'sd0, 8'sd0, 8'sd1});
        expect_row(2'd0, {8'sd1, 8'sd1, 8'sd1, 8'sd1});
        expect_row(2'd1, {-8'sd1, -8'sd1, -8'sd1, -8'sd1});
        expect_row(2'd2, {8'sd0, 8'sd0, 8'sd0, 8'sd1});
        wait_idle("layer_chain_1");
        write_weight(W1, 2'd3, {8'sd0, 8'sd0, 8'sd1, 8'sd0});
        expect_row(2'd3, {8'sd0, 8'sd0, 8'sd1, 8'sd0});
        wait_idle("layer_chain_1");
        check_outputs("layer_chain_1");
        chain_layer({8'sd55, -8'sd44, 8'sd33, -8'sd22});
        check_outputs("layer_chain_clear");
        write_weight(W1, 2'd0, {8'sd1, 8'sd2, 8'sd3, 8'sd4});
        write_weight(W2, 2'd3, {-8'sd1, 8'sd1, -8'sd1, 8'sd1});
        expect_row(2'd0, {8'sd1, 8'sd2, 8'sd3, 8'sd4});
        expect_row(2'd3, {-8'sd1, 8'sd1, -8'sd1, 8'sd1});
        wait_idle("layer_chain_2");
        check_outputs("layer_chain_2");
    endtask

    task automatic test_random_rows();
        t_vector          w;
        logic [ROW_W-1:0] idx;
        int               remaining;
        int               batch;
        begin_layer(t_vector'($urandom));
        remaining = 20;
        while (remaining > 0) begin
            batch = 1 + int'($urandom % NUM_SLOTS);
            if (batch > remaining) begin
                batch = remaining;
            end
            for (int s = 0; s < batch; s++) begin
                w   = t_vector'($urandom);
                idx = ROW_W'($urandom % VEC_LEN);
                write_weight(t_buffer_sel'(s + 1), idx, w);
                expect_row(idx, w);
            end
            remaining -= batch;
            wait_idle("random_rows");
            check_outputs("random_rows");
        end
    endtask

    initial begin : watchdog
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge Clock);
            cycles++;
        end
        $display("Timeout: run stopped after %0d cycles without finishing", cycles);
        $display("Checks: %0d, errors: %0d", checks, errors + 1);
        $display("Test failed");
        $finish;
    end

    initial begin
        rst         = 1'b1;
        load_input  = 1'b0;
        end_input   = 1'b0;
        input_data  = '0;
        weight_load = 1'b0;
        weight_slot = FREE;
        weight_data = '0;
        done_layer  = 1'b0;
        errors      = 0;
        checks      = 0;
        void'($urandom(32'h05e7_5c2a));
        for (int i = 0; i < VEC_LEN; i++) begin
            exp_acc[i] = 0;
            exp_vec[i] = 0;
        end
        repeat (10) @(posedge Clock);
        #1;
        rst = 1'b0;
        step();
        check_outputs("reset");
        test_single_row();
        test_three_slots();
        test_accumulation();
        test_ignored_write();
        test_layer_chain();
        test_random_rows();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/accel_pkg.sv
logic/input_buffer.sv
logic/weight_slots.sv
logic/mul_controller.sv
logic/dot_unit.sv
logic/output_buffer.sv
logic/accel_core.sv
sim/accel_core_chk.sv
sim/accel_core_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = accel_core_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
